// ==== src/em_pkg.sv ====
package em_pkg;

	// Address split of the shared memory: buffer pointer above, word index below.
	localparam int BPTR_NBITS     = 4; // Selects one of the 16 buffers.
	localparam int BPTR_LSB_NBITS = 2; // Selects a word inside a buffer.
	localparam int DATA_NBITS     = 32;
	localparam int ID_NBITS       = 2; // Output port id.

	localparam int NUM_PORTS  = 4;
	localparam int NUM_BUFS   = 16; // Must equal 2**BPTR_NBITS for the free list wrap.
	localparam int DESC_DEPTH = 4;  // Descriptors waiting per output port.

	typedef logic [BPTR_NBITS-1:0] buf_ptr_t;

	// One packet waiting for readout. A packet always starts at word 0 of its buffer,
	// so the pointer and the index of the last word describe it completely.
	typedef struct packed {
		buf_ptr_t                  buf_ptr;
		logic [BPTR_LSB_NBITS-1:0] last_idx;
	} desc_t;

endpackage

// ==== src/em_ifs.sv ====
`timescale 1ns/100ps

// Word write from the packet writer into the shared memory.
interface em_wr_if;
	import em_pkg::*;

	logic                      valid;
	buf_ptr_t                  buf_ptr;
	logic [BPTR_LSB_NBITS-1:0] buf_ptr_lsb;
	logic [DATA_NBITS-1:0]     data;

	modport source (output valid, buf_ptr, buf_ptr_lsb, data);
	modport sink (input valid, buf_ptr, buf_ptr_lsb, data);
endinterface

// Read request from one port reader. The reader holds req and the fields
// stable until the arbiter pulses grant for one cycle.
interface em_req_if;
	import em_pkg::*;

	logic                      req;
	logic                      grant;
	buf_ptr_t                  buf_ptr;
	logic [BPTR_LSB_NBITS-1:0] buf_ptr_lsb;
	logic                      sop;
	logic                      eop;

	modport reader (output req, buf_ptr, buf_ptr_lsb, sop, eop, input grant);
	modport arbiter (input req, buf_ptr, buf_ptr_lsb, sop, eop, output grant);
endinterface

// ==== src/ram_1r1w.sv ====
`timescale 1ns/100ps

module ram_1r1w #(
	parameter type data_t = logic [31:0],
	parameter int  depth  = 16
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(depth)-1:0] waddr,
	input  logic [$clog2(depth)-1:0] raddr,
	input  data_t                    wdata,
	output data_t                    rdata
);

	data_t mem [depth];

	// Registered read. A read of the address being written returns the old contents,
	// so callers that need the new value have to bypass it themselves.
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

endmodule

// ==== src/buf_free_list.sv ====
`timescale 1ns/100ps

module buf_free_list (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             alloc,
	output em_pkg::buf_ptr_t alloc_ptr,
	output logic             empty,
	output logic             init_done,
	input  logic             rel_valid,
	input  em_pkg::buf_ptr_t rel_ptr
);
	import em_pkg::*;

	buf_ptr_t            wr_ptr; // Also counts the pointers written during init.
	buf_ptr_t            rd_ptr;
	buf_ptr_t            rd_ptr_next;
	logic [BPTR_NBITS:0] count; // Holds 0 to 16 free buffers.
	logic                push;
	logic                pop;
	buf_ptr_t            push_ptr;
	buf_ptr_t            ram_rdata;
	logic                byp;
	buf_ptr_t            byp_ptr;

	assign push     = !init_done || rel_valid; // Init fills every slot with its own index.
	assign push_ptr = init_done ? rel_ptr : wr_ptr;
	assign pop      = alloc && !empty;
	assign empty    = (count == '0);

	// The RAM is addressed with the next read pointer, so after each edge its output
	// already holds the new head and alloc_ptr needs no extra cycle.
	assign rd_ptr_next = rd_ptr + buf_ptr_t'(pop);
	assign alloc_ptr   = byp ? byp_ptr : ram_rdata; // A head written in the read cycle is stale.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			init_done <= 1'b0;
			byp       <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			rd_ptr <= rd_ptr_next;
			count  <= count + (BPTR_NBITS+1)'(push) - (BPTR_NBITS+1)'(pop);
			if (!init_done && wr_ptr == buf_ptr_t'(NUM_BUFS-1)) begin
				init_done <= 1'b1; // Last of the 16 init writes.
			end
			byp <= push && (wr_ptr == rd_ptr_next); // Only when the list runs dry.
		end
	end

	always_ff @(posedge clk) begin
		byp_ptr <= push_ptr;
	end

	ram_1r1w #(.data_t(buf_ptr_t), .depth(NUM_BUFS)) u_ram_1r1w (
		.clk   (clk),
		.we    (push),
		.waddr (wr_ptr),
		.raddr (rd_ptr_next),
		.wdata (push_ptr),
		.rdata (ram_rdata)
	);

endmodule

// ==== src/pkt_writer.sv ====
`timescale 1ns/100ps

module pkt_writer (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            in_valid,
	input  logic                            in_sop,
	input  logic                            in_eop,
	input  logic [em_pkg::ID_NBITS-1:0]     in_port,
	input  logic [em_pkg::DATA_NBITS-1:0]   in_data,
	output logic                            in_ready,
	output logic                            alloc,
	input  em_pkg::buf_ptr_t                alloc_ptr,
	input  logic                            empty,
	input  logic                            init_done,
	input  logic [em_pkg::NUM_PORTS-1:0]    q_full,
	output logic [em_pkg::NUM_PORTS-1:0]    desc_valid,
	output em_pkg::desc_t                   desc,
	em_wr_if.source                         wr
);
	import em_pkg::*;

	buf_ptr_t                  cur_ptr;  // Buffer of the packet in progress.
	logic [ID_NBITS-1:0]       cur_port;
	logic [BPTR_LSB_NBITS-1:0] word_idx; // Slot of the next non-sop word.
	logic                      accept;
	buf_ptr_t                  word_ptr;
	logic [BPTR_LSB_NBITS-1:0] word_lsb;
	logic [ID_NBITS-1:0]       word_port;

	// A new packet needs a free buffer and room in its port's queue. A descriptor still
	// being posted is not yet counted in q_full, so a sop waits for that cycle too.
	assign in_ready = init_done &&
		(!in_sop || (!(|desc_valid) && !empty && !q_full[in_port]));
	assign accept = in_valid && in_ready;
	assign alloc  = accept && in_sop; // Pop the free list head on every packet start.

	// The sop word goes to slot 0 of the head buffer, later words follow in order.
	assign word_ptr  = in_sop ? alloc_ptr : cur_ptr;
	assign word_lsb  = in_sop ? '0 : word_idx;
	assign word_port = in_sop ? in_port : cur_port;

	assign wr.valid       = accept;
	assign wr.buf_ptr     = word_ptr;
	assign wr.buf_ptr_lsb = word_lsb;
	assign wr.data        = in_data;

	always_ff @(posedge clk) begin
		if (accept) begin
			cur_ptr  <= word_ptr;
			cur_port <= word_port;
			word_idx <= word_lsb + 1'b1;
		end
		if (accept && in_eop) begin
			desc <= '{buf_ptr: word_ptr, last_idx: word_lsb};
		end
	end

	// The descriptor strobe follows the eop write by one cycle and selects one port.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			desc_valid <= '0;
		end else begin
			desc_valid <= (accept && in_eop) ? (NUM_PORTS'(1) << word_port) : '0;
		end
	end

endmodule

// ==== src/port_reader.sv ====
`timescale 1ns/100ps

module port_reader (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          desc_valid,
	input  em_pkg::desc_t desc,
	output logic          q_full,
	em_req_if.reader      rq
);
	import em_pkg::*;

	logic [$clog2(DESC_DEPTH)-1:0] wr_ptr;
	logic [$clog2(DESC_DEPTH)-1:0] rd_ptr;
	logic [$clog2(DESC_DEPTH)-1:0] rd_ptr_next;
	logic [$clog2(DESC_DEPTH):0]   count;
	logic                          pop;
	logic                          byp;
	desc_t                         byp_desc;
	desc_t                         ram_rdata;
	desc_t                         head;     // Descriptor being walked.
	logic [BPTR_LSB_NBITS-1:0]     word_idx; // Word of the head packet to request next.

	assign q_full = (count == ($clog2(DESC_DEPTH)+1)'(DESC_DEPTH));

	// Head prefetch, the same scheme as the free list. The RAM reads the slot that will
	// be the head after this edge, and a write into that slot is bypassed.
	assign rd_ptr_next = rd_ptr + ($clog2(DESC_DEPTH))'(pop);
	assign head        = byp ? byp_desc : ram_rdata;

	// The walker pops the descriptor once its last word has been granted.
	assign pop = rq.grant && (word_idx == head.last_idx);

	assign rq.req         = (count != '0);
	assign rq.buf_ptr     = head.buf_ptr;
	assign rq.buf_ptr_lsb = word_idx;
	assign rq.sop         = (word_idx == '0);
	assign rq.eop         = (word_idx == head.last_idx);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			byp      <= 1'b0;
			word_idx <= '0;
		end else begin
			if (desc_valid) begin
				wr_ptr <= wr_ptr + 1'b1; // The writer never posts to a full queue.
			end
			rd_ptr <= rd_ptr_next;
			count  <= count + ($clog2(DESC_DEPTH)+1)'(desc_valid)
				- ($clog2(DESC_DEPTH)+1)'(pop);
			byp <= desc_valid && (wr_ptr == rd_ptr_next);
			if (rq.grant) begin
				word_idx <= pop ? '0 : word_idx + 1'b1; // Restart at word 0 for the next packet.
			end
		end
	end

	always_ff @(posedge clk) begin
		byp_desc <= desc;
	end

	ram_1r1w #(.data_t(desc_t), .depth(DESC_DEPTH)) u_ram_1r1w (
		.clk   (clk),
		.we    (desc_valid),
		.waddr (wr_ptr),
		.raddr (rd_ptr_next),
		.wdata (desc),
		.rdata (ram_rdata)
	);

endmodule

// ==== src/read_arbiter.sv ====
`timescale 1ns/100ps

module read_arbiter (
	input  logic                                clk,
	input  logic                                rst_n,
	em_req_if.arbiter                           rq [em_pkg::NUM_PORTS],
	output logic                                data_req,
	output logic [em_pkg::ID_NBITS-1:0]         data_req_port,
	output logic                                data_req_sop,
	output logic                                data_req_eop,
	output em_pkg::buf_ptr_t                    data_req_buf_ptr,
	output logic [em_pkg::BPTR_LSB_NBITS-1:0]   data_req_buf_ptr_lsb
);
	import em_pkg::*;

	logic [NUM_PORTS-1:0]      req_vec;
	logic [NUM_PORTS-1:0]      sop_vec;
	logic [NUM_PORTS-1:0]      eop_vec;
	buf_ptr_t                  ptr_arr [NUM_PORTS];
	logic [BPTR_LSB_NBITS-1:0] lsb_arr [NUM_PORTS];
	logic [ID_NBITS-1:0]       last_id; // Port granted most recently.
	logic [ID_NBITS-1:0]       win;
	logic [ID_NBITS-1:0]       cand;
	logic                      found;

	// Interface arrays cannot take a variable index, so the fields are unpacked here.
	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		assign req_vec[p]  = rq[p].req;
		assign sop_vec[p]  = rq[p].sop;
		assign eop_vec[p]  = rq[p].eop;
		assign ptr_arr[p]  = rq[p].buf_ptr;
		assign lsb_arr[p]  = rq[p].buf_ptr_lsb;
		assign rq[p].grant = found && (win == ID_NBITS'(p)); // Same-cycle grant.
	end

	// Search starts one past the last winner and wraps, so the last winner comes last.
	always_comb begin
		found = 1'b0;
		win   = last_id;
		cand  = last_id;
		for (int i = 1; i <= NUM_PORTS; i++) begin
			cand = last_id + ID_NBITS'(i);
			if (!found && req_vec[cand]) begin
				found = 1'b1;
				win   = cand;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_req <= 1'b0;
			last_id  <= ID_NBITS'(NUM_PORTS-1); // Port 0 goes first after reset.
		end else begin
			data_req <= found;
			if (found) begin
				last_id <= win;
			end
		end
	end

	always_ff @(posedge clk) begin
		data_req_port        <= win;
		data_req_sop         <= sop_vec[win];
		data_req_eop         <= eop_vec[win];
		data_req_buf_ptr     <= ptr_arr[win];
		data_req_buf_ptr_lsb <= lsb_arr[win];
	end

endmodule

// ==== src/edit_mem_shared_memory.sv ====
`timescale 1ns/100ps

module edit_mem_shared_memory (
	input  logic                              clk,
	input  logic                              rst_n,
	em_wr_if.sink                             wr,
	input  logic                              data_req,
	input  logic [em_pkg::ID_NBITS-1:0]       data_req_dst_port_id,
	input  logic                              data_req_sop,
	input  logic                              data_req_eop,
	input  em_pkg::buf_ptr_t                  data_req_buf_ptr,
	input  logic [em_pkg::BPTR_LSB_NBITS-1:0] data_req_buf_ptr_lsb,
	output logic                              em_rel_buf_valid,
	output em_pkg::buf_ptr_t                  em_rel_buf_ptr,
	output logic                              edit_mem_ack,
	output logic [em_pkg::DATA_NBITS-1:0]     edit_mem_rdata,
	output logic [em_pkg::ID_NBITS-1:0]       edit_mem_port,
	output logic                              edit_mem_sop,
	output logic                              edit_mem_eop
);
	import em_pkg::*;

	logic                      data_req_d1;
	logic                      data_req_d2;
	logic [ID_NBITS-1:0]       port_d1;
	logic [ID_NBITS-1:0]       port_d2;
	logic                      sop_d1;
	logic                      sop_d2;
	logic                      eop_d1;
	logic                      eop_d2;
	buf_ptr_t                  rd_ptr_d1;
	logic [BPTR_LSB_NBITS-1:0] rd_lsb_d1;
	logic                      wr_valid_d1;
	buf_ptr_t                  wr_ptr_d1;
	logic [BPTR_LSB_NBITS-1:0] wr_lsb_d1;
	logic [DATA_NBITS-1:0]     wr_data_d1;
	logic [DATA_NBITS-1:0]     ram_rdata;

	// Both ports are registered once before the RAM. The tags ride two stages
	// to meet the RAM output and then one more with the data register.
	always_ff @(posedge clk) begin
		port_d1    <= data_req_dst_port_id;
		sop_d1     <= data_req_sop;
		eop_d1     <= data_req_eop;
		rd_ptr_d1  <= data_req_buf_ptr;
		rd_lsb_d1  <= data_req_buf_ptr_lsb;
		port_d2    <= port_d1;
		sop_d2     <= sop_d1;
		eop_d2     <= eop_d1;
		wr_ptr_d1  <= wr.buf_ptr;
		wr_lsb_d1  <= wr.buf_ptr_lsb;
		wr_data_d1 <= wr.data;
		edit_mem_rdata <= ram_rdata;
		edit_mem_port  <= port_d2;
		edit_mem_sop   <= sop_d2;
		edit_mem_eop   <= eop_d2;
		em_rel_buf_ptr <= rd_ptr_d1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_req_d1      <= 1'b0;
			data_req_d2      <= 1'b0;
			wr_valid_d1      <= 1'b0;
			em_rel_buf_valid <= 1'b0;
			edit_mem_ack     <= 1'b0;
		end else begin
			data_req_d1  <= data_req;
			data_req_d2  <= data_req_d1;
			wr_valid_d1  <= wr.valid;
			edit_mem_ack <= data_req_d2; // Three cycles after the request.
			// The read of the buffer's last word has gone to the RAM, so it can be reused.
			em_rel_buf_valid <= data_req_d1 && (eop_d1 || (&rd_lsb_d1));
		end
	end

	ram_1r1w #(
		.data_t (logic [DATA_NBITS-1:0]),
		.depth  (NUM_BUFS * (2 ** BPTR_LSB_NBITS))
	) u_ram_1r1w (
		.clk   (clk),
		.we    (wr_valid_d1),
		.waddr ({wr_ptr_d1, wr_lsb_d1}),
		.raddr ({rd_ptr_d1, rd_lsb_d1}),
		.wdata (wr_data_d1),
		.rdata (ram_rdata)
	);

endmodule

// ==== src/em_top.sv ====
`timescale 1ns/100ps

module em_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_valid,
	input  logic                          in_sop,
	input  logic                          in_eop,
	input  logic [em_pkg::ID_NBITS-1:0]   in_port,
	input  logic [em_pkg::DATA_NBITS-1:0] in_data,
	output logic                          in_ready,
	output logic                          out_valid,
	output logic [em_pkg::ID_NBITS-1:0]   out_port,
	output logic                          out_sop,
	output logic                          out_eop,
	output logic [em_pkg::DATA_NBITS-1:0] out_data
);
	import em_pkg::*;

	logic                      alloc;
	buf_ptr_t                  alloc_ptr;
	logic                      fl_empty;
	logic                      init_done;
	logic                      rel_valid;
	buf_ptr_t                  rel_ptr;
	logic [NUM_PORTS-1:0]      q_full;
	logic [NUM_PORTS-1:0]      desc_valid;
	desc_t                     desc; // Broadcast, desc_valid picks the port.
	logic                      data_req;
	logic [ID_NBITS-1:0]       data_req_port;
	logic                      data_req_sop;
	logic                      data_req_eop;
	buf_ptr_t                  data_req_buf_ptr;
	logic [BPTR_LSB_NBITS-1:0] data_req_buf_ptr_lsb;

	em_wr_if  wr_if ();
	em_req_if rq_if [NUM_PORTS] ();

	buf_free_list u_buf_free_list (
		.clk       (clk),
		.rst_n     (rst_n),
		.alloc     (alloc),
		.alloc_ptr (alloc_ptr),
		.empty     (fl_empty),
		.init_done (init_done),
		.rel_valid (rel_valid),
		.rel_ptr   (rel_ptr)
	);

	pkt_writer u_pkt_writer (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_sop     (in_sop),
		.in_eop     (in_eop),
		.in_port    (in_port),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.alloc      (alloc),
		.alloc_ptr  (alloc_ptr),
		.empty      (fl_empty),
		.init_done  (init_done),
		.q_full     (q_full),
		.desc_valid (desc_valid),
		.desc       (desc),
		.wr         (wr_if)
	);

	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_reader
		port_reader u_port_reader (
			.clk        (clk),
			.rst_n      (rst_n),
			.desc_valid (desc_valid[g]),
			.desc       (desc),
			.q_full     (q_full[g]),
			.rq         (rq_if[g])
		);
	end

	read_arbiter u_read_arbiter (
		.clk                  (clk),
		.rst_n                (rst_n),
		.rq                   (rq_if),
		.data_req             (data_req),
		.data_req_port        (data_req_port),
		.data_req_sop         (data_req_sop),
		.data_req_eop         (data_req_eop),
		.data_req_buf_ptr     (data_req_buf_ptr),
		.data_req_buf_ptr_lsb (data_req_buf_ptr_lsb)
	);

	edit_mem_shared_memory u_edit_mem_shared_memory (
		.clk                  (clk),
		.rst_n                (rst_n),
		.wr                   (wr_if),
		.data_req             (data_req),
		.data_req_dst_port_id (data_req_port),
		.data_req_sop         (data_req_sop),
		.data_req_eop         (data_req_eop),
		.data_req_buf_ptr     (data_req_buf_ptr),
		.data_req_buf_ptr_lsb (data_req_buf_ptr_lsb),
		.em_rel_buf_valid     (rel_valid),
		.em_rel_buf_ptr       (rel_ptr),
		.edit_mem_ack         (out_valid),
		.edit_mem_rdata       (out_data),
		.edit_mem_port        (out_port),
		.edit_mem_sop         (out_sop),
		.edit_mem_eop         (out_eop)
	);

endmodule

// ==== tests/em_asserts.sv ====
`timescale 1ns/100ps

module em_asserts (
	input logic                              clk,
	input logic                              rst_n,
	input logic                              data_req,
	input logic                              data_req_eop,
	input logic [em_pkg::BPTR_LSB_NBITS-1:0] data_req_buf_ptr_lsb,
	input logic                              edit_mem_ack,
	input logic                              em_rel_buf_valid
);

	logic rel_req; // The request reads the last word the buffer will give out.

	assign rel_req = data_req && (data_req_eop || (&data_req_buf_ptr_lsb));

	a_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
		data_req |-> ##3 edit_mem_ack)
		else $error("Ack missing three cycles after a read request.");

	a_ack_has_req: assert property (@(posedge clk) disable iff (!rst_n)
		edit_mem_ack |-> $past(data_req, 3))
		else $error("Ack without a read request three cycles earlier.");

	a_rel_follows_last: assert property (@(posedge clk) disable iff (!rst_n)
		rel_req |-> ##2 em_rel_buf_valid)
		else $error("Buffer release missing two cycles after a last-word read.");

	a_rel_has_last: assert property (@(posedge clk) disable iff (!rst_n)
		em_rel_buf_valid |-> $past(rel_req, 2))
		else $error("Buffer released without a last-word read two cycles earlier.");

	// Registers clear one edge into reset.
	a_quiet_in_reset: assert property (@(posedge clk)
		$past(!rst_n) |-> (!edit_mem_ack && !em_rel_buf_valid))
		else $error("Memory outputs active during reset.");

endmodule

bind edit_mem_shared_memory em_asserts u_em_asserts (
	.clk                  (clk),
	.rst_n                (rst_n),
	.data_req             (data_req),
	.data_req_eop         (data_req_eop),
	.data_req_buf_ptr_lsb (data_req_buf_ptr_lsb),
	.edit_mem_ack         (edit_mem_ack),
	.em_rel_buf_valid     (em_rel_buf_valid)
);

// ==== tests/tb_em_top.sv ====
`timescale 1ns/100ps

module tb_em_top;
	import em_pkg::*;

	localparam int NUM_ROWS       = 64;
	localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 200; // Generous bound on the whole run.
	localparam int DRAIN_CYCLES   = 100; // Longest wait for the last words once input stops.

	// One packet to send. Word i of the packet carries first + i.
	typedef struct packed {
		logic [ID_NBITS-1:0]   port;
		logic [2:0]            len; // 1 to 4 words.
		logic [DATA_NBITS-1:0] first;
	} row_t;

	logic                  clk;
	logic                  rst_n;
	logic                  in_valid;
	logic                  in_sop;
	logic                  in_eop;
	logic [ID_NBITS-1:0]   in_port;
	logic [DATA_NBITS-1:0] in_data;
	logic                  in_ready;
	logic                  out_valid;
	logic [ID_NBITS-1:0]   out_port;
	logic                  out_sop;
	logic                  out_eop;
	logic [DATA_NBITS-1:0] out_data;

	row_t                  rows [NUM_ROWS];
	logic [DATA_NBITS+1:0] exp_q [NUM_PORTS][$]; // Expected {sop, eop, data} per port.
	logic [DATA_NBITS+1:0] exp_word;
	int                    error_count   = 0;
	int                    words_checked = 0;
	int                    full_stalls   = 0; // Cycles where a full queue held off a sop.
	int                    cycle_count   = 0;
	int                    drain_count   = 0;
	int unsigned           seed_val;

	em_top u_em_top (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period.
	end

	// Watchdog. The run has to finish well inside this many cycles.
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Outputs are registers, so the falling edge sees them settled.
	always @(negedge clk) begin
		if (in_valid && !in_ready && in_sop && u_em_top.q_full[in_port]) begin
			full_stalls++;
		end
		if (rst_n && out_valid) begin
			if (exp_q[out_port].size() == 0) begin
				error_count++;
				$display("[ERROR] %0t: word %h out on port %0d was never expected",
					$time, out_data, out_port);
			end else begin
				exp_word = exp_q[out_port].pop_front();
				words_checked++;
				if (out_data !== exp_word[DATA_NBITS-1:0] || out_sop !== exp_word[DATA_NBITS+1]
						|| out_eop !== exp_word[DATA_NBITS]) begin
					error_count++;
					$display("[ERROR] %0t: port %0d got data %h sop %b eop %b, expected %h %b %b",
						$time, out_port, out_data, out_sop, out_eop, exp_word[DATA_NBITS-1:0],
						exp_word[DATA_NBITS+1], exp_word[DATA_NBITS]);
				end
			end
		end
	end

	task automatic set_row(input int idx, input int port, input int len, input int first);
		rows[idx] = '{port: ID_NBITS'(port), len: 3'(len), first: DATA_NBITS'(first)};
	endtask

	task automatic fill_table();
		for (int p = 0; p < NUM_PORTS; p++) begin
			set_row(2 * p, p, 1, 32'h1000_0000 + (p << 8));     // Single word to each port.
			set_row(2 * p + 1, p, 4, 32'h2000_0000 + (p << 8)); // Full buffer to each port.
		end
		for (int i = 8; i < 16; i++) begin
			set_row(i, i % NUM_PORTS, 4, 32'h3000_0000 + (i << 4)); // All ports busy at once.
		end
		set_row(16, 0, 4, 32'h4000_0000); // Keep the other readers busy so port 2 fills up.
		set_row(17, 1, 4, 32'h4100_0000);
		set_row(18, 3, 4, 32'h4300_0000);
		for (int i = 19; i < 24; i++) begin
			set_row(i, 2, 1, 32'h5000_0000 + (i << 4)); // Burst of five to port 2.
		end
		for (int i = 24; i < NUM_ROWS; i++) begin
			set_row(i, $urandom % NUM_PORTS, 1 + $urandom % 4, $urandom); // Forty random.
		end
	endtask

	// Drive one word and hold it until in_ready is seen high at a falling edge.
	task automatic send_word(input logic [ID_NBITS-1:0] port, input logic sop, input logic eop,
			input logic [DATA_NBITS-1:0] data);
		logic accepted;
		accepted = 1'b0;
		in_valid = 1'b1;
		in_sop   = sop;
		in_eop   = eop;
		in_port  = port;
		in_data  = data;
		while (!accepted) begin
			@(negedge clk);
			accepted = in_ready;
			@(posedge clk);
			#1;
		end
		exp_q[port].push_back({sop, eop, data}); // Taken at the edge just passed.
	endtask

	task automatic send_packet(input row_t row);
		for (int i = 0; i < int'(row.len); i++) begin
			send_word(row.port, i == 0, i == int'(row.len) - 1, row.first + DATA_NBITS'(i));
		end
	endtask

	function automatic int pending_words();
		int total;
		total = 0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			total += exp_q[p].size();
		end
		return total;
	endfunction

	initial begin
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_sop   = 1'b0;
		in_eop   = 1'b0;
		in_port  = '0;
		in_data  = '0;
		seed_val = $urandom(32'h3e23); // Seeds the generator for the whole run.
		fill_table();
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++) begin
			send_packet(rows[r]);
		end
		in_valid = 1'b0;
		in_sop   = 1'b0;
		in_eop   = 1'b0;
		while (pending_words() != 0 && drain_count < DRAIN_CYCLES) begin
			@(posedge clk);
			drain_count++;
		end
		repeat (20) @(posedge clk); // Any stray word would show up in this window.
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (exp_q[p].size() != 0) begin
				error_count++;
				$display("Port %0d still waits for %0d words at the end.", p, exp_q[p].size());
			end
		end
		$display("Checked %0d words, %0d full-queue stalls, %0d errors.", words_checked,
			full_stalls, error_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
src/em_pkg.sv
src/em_ifs.sv
src/ram_1r1w.sv
src/buf_free_list.sv
src/pkt_writer.sv
src/port_reader.sv
src/read_arbiter.sv
src/edit_mem_shared_memory.sv
src/em_top.sv
tests/em_asserts.sv
tests/tb_em_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_em_top -f verilog.f \
	-o tb_em_top > build.log 2>&1 || { cat build.log; echo "Build failed."; exit 1; }
./obj_dir/tb_em_top > sim.log 2>&1
cat sim.log
grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1
